// File: filelist.f
logic/conv_layer_pkg.sv
logic/conv_weights_pkg.sv
logic/layer_sequencer.sv
logic/channel_dot.sv
logic/requantizer.sv
logic/conv1d_layer.sv
tb/conv1d_layer_chk.sv
tb/tb_conv1d_layer.sv

// File: logic/channel_dot.sv
`timescale 1ns/10ps

module channel_dot
	import conv_layer_pkg::*;
	import conv_weights_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  window_t             window,
	input  logic                issue_valid,
	input  logic [CH_IDX_W-1:0] issue_idx,
	input  logic                issue_last,
	output logic                dot_valid,
	output acc_t                dot_sum,
	output logic [CH_IDX_W-1:0] dot_idx,
	output logic                dot_last
);

	acc_t sum;

	// 40 products of the window with the weight row of issue_idx.
	// Samples are unsigned, so they get a zero sign bit before the multiply.
	always_comb begin
		sum = '0;
		for (int i = 0; i < IN_CH; i++) begin
			for (int k = 0; k < TAPS; k++) begin
				sum = sum + acc_t'($signed({1'b0, window[i][k]}))
					* acc_t'(LAYER_WEIGHTS[issue_idx][i][k]);
			end
		end
	end

	// Tags.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dot_valid <= 1'b0;
			dot_last  <= 1'b0;
		end else begin
			dot_valid <= issue_valid;
			dot_last  <= issue_valid && issue_last;
		end
	end

	// Payload follows the tags one edge after the issue.
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			dot_sum <= sum;
			dot_idx <= issue_idx;
		end
	end

endmodule

// File: logic/conv1d_layer.sv
`timescale 1ns/10ps

module conv1d_layer import conv_layer_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en,
	input  window_t              window_in,
	output logic                 busy,
	output logic                 done,
	output result_t [OUT_CH-1:0] result
);

	window_t             window;   // Held copy of the accepted window.
	logic                issue_valid;
	logic [CH_IDX_W-1:0] issue_idx;
	logic                issue_last;

	logic                dot_valid;
	acc_t                dot_sum;
	logic [CH_IDX_W-1:0] dot_idx;
	logic                dot_last;

	layer_sequencer u_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.en          (en),
		.window_in   (window_in),
		.busy        (busy),
		.window      (window),
		.issue_valid (issue_valid),
		.issue_idx   (issue_idx),
		.issue_last  (issue_last)
	);

	channel_dot u_dot (
		.clk         (clk),
		.rst_n       (rst_n),
		.window      (window),
		.issue_valid (issue_valid),
		.issue_idx   (issue_idx),
		.issue_last  (issue_last),
		.dot_valid   (dot_valid),
		.dot_sum     (dot_sum),
		.dot_idx     (dot_idx),
		.dot_last    (dot_last)
	);

	requantizer u_requant (
		.clk       (clk),
		.rst_n     (rst_n),
		.dot_valid (dot_valid),
		.dot_sum   (dot_sum),
		.dot_idx   (dot_idx),
		.dot_last  (dot_last),
		.result    (result),
		.done      (done)
	);

endmodule

// File: logic/conv_layer_pkg.sv
package conv_layer_pkg;

	// Layer dimensions.
	localparam int IN_CH    = 8;    // Input channels.
	localparam int OUT_CH   = 16;   // Output channels.
	localparam int TAPS     = 5;    // Samples per input channel.

	// Datapath widths.
	localparam int DATA_W   = 8;    // Unsigned sample.
	localparam int WEIGHT_W = 8;    // Signed weight.
	localparam int ACC_W    = 22;   // Holds 40 products of 255 * -128 with room to spare.
	localparam int RES_W    = 8;    // Signed output.
	localparam int CH_IDX_W = $clog2(OUT_CH);

	// Requantization.
	localparam int SHIFT    = 9;
	localparam int SAT_MAX  = 127;
	localparam int SAT_MIN  = -127;  // Symmetric range, -128 is never produced.

	// Full input window, window[i][k] is tap k of input channel i.
	typedef logic [IN_CH-1:0][TAPS-1:0][DATA_W-1:0] window_t;

	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic signed [RES_W-1:0] result_t;

endpackage

// File: logic/conv_weights_pkg.sv
package conv_weights_pkg;

	import conv_layer_pkg::*;

	// Indexed [output channel][input channel][tap].
	// Each row is listed from tap 4 down to tap 0.
	localparam logic signed [WEIGHT_W-1:0] LAYER_WEIGHTS [OUT_CH][IN_CH][TAPS-1:0] = '{
		'{'{-76,-3,-4,45,30}, '{72,-25,-93,55,-46}, '{-83,-85,-14,-61,-11}, '{4,-37,91,-15,73},
		  '{78,-86,-2,-39,15}, '{38,47,86,-48,44}, '{40,11,39,-7,-15}, '{-18,-7,-37,62,-22}},
		'{'{17,50,52,-81,79}, '{35,-22,-1,2,-83}, '{-17,-26,-83,-9,-43}, '{126,94,76,17,44},
		  '{7,-45,-87,-7,-71}, '{3,-11,30,70,47}, '{26,-80,-40,62,-11}, '{-15,61,-68,-41,-23}},
		'{'{-14,14,-27,-47,-40}, '{-40,-72,29,-43,-40}, '{19,9,-90,4,22}, '{-67,41,48,-45,-45},
		  '{30,-52,-66,-69,-36}, '{-60,34,-72,51,69}, '{36,-77,-3,-55,-19}, '{15,72,33,70,86}},
		'{'{83,76,-63,64,-83}, '{-41,-51,69,108,-8}, '{-35,-5,-65,96,-6}, '{1,-103,34,31,-91},
		  '{-31,-14,99,-65,27}, '{63,-21,62,23,-19}, '{-71,-1,64,-54,85}, '{19,-65,7,46,13}},
		'{'{-30,61,-81,51,-23}, '{-41,36,-47,-32,40}, '{-11,-50,-38,-46,-62}, '{-1,-43,-93,46,31},
		  '{-12,44,-59,74,22}, '{-23,66,58,65,-3}, '{44,59,-14,19,-15}, '{23,-63,-71,6,17}},
		'{'{-20,-11,25,-75,73}, '{-25,78,-41,-1,-27}, '{27,-16,-57,-58,-8}, '{29,-3,99,-29,100},
		  '{-21,-18,-67,-26,4}, '{30,23,21,-11,33}, '{-64,-51,-28,-64,-13}, '{24,-2,7,-6,-11}},
		'{'{-39,-43,-26,-58,-19}, '{-17,31,32,76,15}, '{69,56,-5,-14,-38}, '{-57,-46,7,51,60},
		  '{41,67,73,-22,-12}, '{21,-10,-73,-12,66}, '{-69,-97,1,-17,43}, '{48,16,38,-66,44}},
		'{'{-10,30,-11,-63,-60}, '{-44,-15,78,36,-7}, '{-7,1,52,1,-4}, '{-9,-89,34,-13,46},
		  '{-16,63,33,5,36}, '{-15,85,74,-16,78}, '{-68,5,2,53,65}, '{70,-38,80,21,26}},
		'{'{75,-69,82,-35,1}, '{28,47,-57,1,103}, '{-44,58,-66,-8,54}, '{25,39,-59,17,-90},
		  '{-28,52,47,50,-17}, '{53,84,85,-28,8}, '{34,-60,-9,34,-45}, '{-35,-5,22,38,-59}},
		'{'{-45,36,-5,38,-11}, '{-28,-50,-72,-3,-17}, '{51,-74,-68,62,-18}, '{43,77,-41,113,127},
		  '{50,46,7,37,12}, '{-65,44,51,14,49}, '{36,-76,-84,-45,-109}, '{14,-4,-48,-82,35}},
		'{'{-66,11,17,74,31}, '{48,24,-6,-11,56}, '{29,-10,-19,18,72}, '{35,49,-18,-60,-74},
		  '{-27,-47,10,-70,-72}, '{-36,-2,-41,38,57}, '{51,-10,77,31,26}, '{-60,2,-52,-34,-18}},
		'{'{-69,-15,31,-56,59}, '{4,29,-23,-84,5}, '{-69,-37,-66,-56,-45}, '{7,-6,-35,83,70},
		  '{-28,60,-16,-61,-72}, '{98,86,90,-50,24}, '{55,-23,-54,-5,-46}, '{-50,-71,67,50,20}},
		'{'{76,-67,82,38,35}, '{69,31,33,0,-83}, '{-60,-94,-39,-94,-3}, '{63,-4,62,-13,51},
		  '{36,16,30,-31,37}, '{-69,35,2,70,60}, '{9,8,-65,-50,23}, '{-77,-4,-11,-43,-6}},
		'{'{43,-42,-30,-31,56}, '{42,-8,-50,34,13}, '{96,39,15,-32,24}, '{-10,-75,-65,-103,-54},
		  '{52,-1,60,-69,93}, '{19,59,-82,-19,-1}, '{-51,55,-23,47,63}, '{-13,-68,52,75,67}},
		'{'{79,-85,-24,66,-72}, '{-61,23,-48,-22,-26}, '{-84,17,53,45,62}, '{67,-31,45,20,59},
		  '{13,-45,-49,4,37}, '{75,20,-41,-39,17}, '{-31,-58,-22,-76,6}, '{-52,29,22,0,-81}},
		'{'{-12,0,67,34,-79}, '{-29,-50,-56,6,13}, '{26,17,58,38,29}, '{-2,33,-28,-30,-25},
		  '{30,51,-58,57,79}, '{30,-8,-41,-39,-23}, '{68,-29,-38,-5,90}, '{37,42,-90,-44,49}}
	};

endpackage

// File: logic/layer_sequencer.sv
`timescale 1ns/10ps

module layer_sequencer import conv_layer_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                en,
	input  window_t             window_in,
	output logic                busy,
	output window_t             window,
	output logic                issue_valid,
	output logic [CH_IDX_W-1:0] issue_idx,
	output logic                issue_last
);

	logic [CH_IDX_W-1:0] ch_cnt;   // Output channel being issued.
	logic                start;

	// A strobe during a running layer is dropped.
	assign start = en && !busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			ch_cnt <= '0;
		end else if (start) begin
			busy   <= 1'b1;
			ch_cnt <= '0;
		end else if (busy) begin
			ch_cnt <= ch_cnt + 1'b1;
			if (issue_last) begin
				busy <= 1'b0;   // Index 15 goes out this cycle.
			end
		end
	end

	// Window is held for all 16 channels of the layer.
	always_ff @(posedge clk) begin
		if (start) begin
			window <= window_in;
		end
	end

	// One index per busy cycle, starting the cycle after the accept.
	assign issue_valid = busy;
	assign issue_idx   = ch_cnt;
	assign issue_last  = busy && (ch_cnt == CH_IDX_W'(OUT_CH - 1));

endmodule

// File: logic/requantizer.sv
`timescale 1ns/10ps

module requantizer import conv_layer_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  dot_valid,
	input  acc_t                  dot_sum,
	input  logic [CH_IDX_W-1:0]   dot_idx,
	input  logic                  dot_last,
	output result_t [OUT_CH-1:0]  result,
	output logic                  done
);

	acc_t    shifted;
	result_t clamped;
	logic    last_written;   // Final channel of a layer written last edge.

	// Arithmetic shift, then clamp to the symmetric 8-bit range.
	always_comb begin
		shifted = dot_sum >>> SHIFT;
		if (shifted > acc_t'(SAT_MAX)) begin
			clamped = result_t'(SAT_MAX);
		end else if (shifted < acc_t'(SAT_MIN)) begin
			clamped = result_t'(SAT_MIN);
		end else begin
			clamped = result_t'(shifted);   // Fits, upper bits are sign copies.
		end
	end

	// Output bank, one channel per valid cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (dot_valid) begin
			result[dot_idx] <= clamped;
		end
	end

	// Done comes one cycle after the last write of the layer.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_written <= 1'b0;
			done         <= 1'b0;
		end else begin
			last_written <= dot_valid && dot_last;
			done         <= last_written;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the conv1d_layer testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the run ends in $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_conv1d_layer \
	-f filelist.f \
	-o sim_conv1d_layer \
	&& ./obj_dir/sim_conv1d_layer +verilator+error+limit+1000 \
	|| exit 1

// File: tb/conv1d_layer_chk.sv
`timescale 1ns/10ps

module conv1d_layer_chk
	import conv_layer_pkg::*;
	import conv_weights_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 en,
	input  window_t              window_in,
	input  logic                 busy,
	input  logic                 done,
	input  result_t [OUT_CH-1:0] result
);

	typedef result_t [OUT_CH-1:0] layer_out_t;

	localparam int DONE_LAT = 19;   // Accepting edge to the edge that samples done.
	localparam int BUSY_LEN = 17;   // Accepting edge to the first edge that samples busy low.

	layer_out_t exp_mem [4];   // Expected outputs of layers in flight.
	layer_out_t exp_head;
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic       accept;
	logic       pending;
	int         fail_count = 0;   // Read by the testbench.

	// Golden model from the dot product, arithmetic shift and symmetric clamp.
	function automatic layer_out_t golden_layer(input window_t w);
		layer_out_t res;
		int         sum;
		int         q;
		for (int o = 0; o < OUT_CH; o++) begin
			sum = 0;
			for (int i = 0; i < IN_CH; i++) begin
				for (int k = 0; k < TAPS; k++) begin
					sum += int'(w[i][k]) * int'(LAYER_WEIGHTS[o][i][k]);
				end
			end
			q = sum >>> SHIFT;
			if (q > SAT_MAX) begin
				q = SAT_MAX;
			end else if (q < SAT_MIN) begin
				q = SAT_MIN;
			end
			res[o] = result_t'(q);
		end
		return res;
	endfunction

	assign accept   = en && !busy;
	assign pending  = (wr_ptr != rd_ptr);
	assign exp_head = exp_mem[rd_ptr];

	// Expected values queue up at each accepting edge and leave on done.
	always @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (accept) begin
				exp_mem[wr_ptr] <= golden_layer(window_in);
				wr_ptr          <= wr_ptr + 2'd1;
			end
			if (done && pending) begin
				rd_ptr <= rd_ptr + 2'd1;
			end
		end
	end

	a_reset: assert property (@(posedge clk) !rst_n |=> (!busy && !done && result == '0))
		else begin
			$error("Outputs were not cleared by reset");
			fail_count++;
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n) accept |=> busy)
		else begin
			$error("busy did not rise after an accepted start");
			fail_count++;
		end

	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$past(accept, BUSY_LEN) |-> !busy)
		else begin
			$error("busy stayed high past the last issued channel");
			fail_count++;
		end

	a_done_due: assert property (@(posedge clk) disable iff (!rst_n)
		$past(accept, DONE_LAT) |-> done)
		else begin
			$error("done is missing after an accepted start");
			fail_count++;
		end

	a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(accept, DONE_LAT))
		else begin
			$error("done came without a matching accepted start");
			fail_count++;
		end

	a_values: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (result == exp_head))
		else begin
			$error("[FAIL] %0t: results differ from the expected layer output", $time);
			fail_count++;
		end

endmodule

bind conv1d_layer conv1d_layer_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.en        (en),
	.window_in (window_in),
	.busy      (busy),
	.done      (done),
	.result    (result)
);

// File: tb/tb_conv1d_layer.sv
`timescale 1ns/10ps

module tb_conv1d_layer
	import conv_layer_pkg::*;
	import conv_weights_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int DRIVE_DLY    = 1;      // Inputs change this long after the rising edge.
	localparam int RESET_CYCLES = 4;
	localparam int N_RANDOM     = 30;
	localparam int MAX_CYCLES   = 2000;   // About 40 layers of 20 cycles, with margin.
	localparam int SEED         = 12799;

	logic                 clk;
	logic                 rst_n;
	logic                 en;
	window_t              window_in;
	logic                 busy;
	logic                 done;
	result_t [OUT_CH-1:0] result;
	int                   cycle_count = 0;

	conv1d_layer UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.window_in (window_in),
		.busy      (busy),
		.done      (done),
		.result    (result)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Watchdog.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	// Assertion failures in the bound checker end the run here.
	always @(negedge clk) begin
		if (UUT.u_chk.fail_count != 0) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "A checker assertion failed");
		end
	end

	// Advance to the drive point of the next cycle.
	task automatic step();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Waits for an idle sequencer, then strobes en for one cycle.
	task automatic start_layer(input window_t w);
		while (busy) begin
			step();
		end
		window_in = w;
		en        = 1'b1;
		step();
		en        = 1'b0;
	endtask

	task automatic wait_done();
		while (!done) begin
			step();
		end
		step();
	endtask

	task automatic run_layer(input window_t w);
		start_layer(w);
		wait_done();
	endtask

	// Strobes en at random while busy, with a different window each time.
	task automatic busy_pulse_layer(input window_t w);
		start_layer(w);
		while (busy) begin
			en        = 1'($urandom_range(0, 1));
			window_in = random_window();
			step();
		end
		en = 1'b0;
		wait_done();
	endtask

	// Second start lands on the first edge that sees busy low.
	task automatic back_to_back(input window_t a, input window_t b);
		start_layer(a);
		start_layer(b);
		wait_done();
		wait_done();
	endtask

	function automatic window_t random_window();
		window_t w;
		for (int i = 0; i < IN_CH; i++) begin
			for (int k = 0; k < TAPS; k++) begin
				w[i][k] = DATA_W'($urandom());
			end
		end
		return w;
	endfunction

	// Full scale on every tap whose weight has the wanted sign, zero elsewhere.
	function automatic window_t extreme_window(input int ch, input bit positive);
		window_t                     w;
		logic signed [WEIGHT_W-1:0] wt;
		for (int i = 0; i < IN_CH; i++) begin
			for (int k = 0; k < TAPS; k++) begin
				wt = LAYER_WEIGHTS[ch][i][k];
				if (positive) begin
					w[i][k] = (wt > 0) ? '1 : '0;
				end else begin
					w[i][k] = (wt < 0) ? '1 : '0;
				end
			end
		end
		return w;
	endfunction

	initial begin
		rst_n     = 1'b0;
		en        = 1'b0;
		window_in = '0;
		void'($urandom(SEED));

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		step();
		step();

		run_layer('0);   // All outputs zero.
		for (int n = 0; n < N_RANDOM; n++) begin
			run_layer(random_window());
		end

		// Saturation at both ends.
		run_layer('1);
		run_layer(extreme_window(0, 1'b1));
		run_layer(extreme_window(0, 1'b0));
		run_layer(extreme_window(9, 1'b1));
		run_layer(extreme_window(9, 1'b0));
		run_layer(extreme_window(14, 1'b1));
		run_layer(extreme_window(14, 1'b0));

		busy_pulse_layer(random_window());
		busy_pulse_layer(extreme_window(5, 1'b1));

		back_to_back(random_window(), random_window());
		back_to_back(extreme_window(3, 1'b0), random_window());

		repeat (4) step();   // Let the last assertions evaluate.

		if (UUT.u_chk.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Checker reported %0d failures", UUT.u_chk.fail_count);
		end
	end

endmodule
